//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    // Data path width and PC step
    localparam int XLEN = 32;
    localparam int INSTR_BYTES = 4;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [31:0]     instr_t;

    ////////////////////////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////////////////////////

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    ////////////////////////////////////////////////////////////
    // Function fields
    ////////////////////////////////////////////////////////////

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_SUB    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

endpackage

//--- rtl/rv_pipe_pkg.sv
package rv_pipe_pkg;

    // Iterations of the shift-add multiplier
    localparam int MUL_CYCLES = 32;

    typedef struct packed {
        rv_isa_pkg::instr_t instr;
        rv_isa_pkg::word_t  pc;
    } fetched_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        OP_ALU,
        OP_BRANCH,
        OP_MUL,
        OP_NOP
    } op_type_e;

    typedef struct packed {
        rv_isa_pkg::word_t    pc;
        op_type_e             op_type;
        alu_op_e              alu_op;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::word_t    imm;
        logic                 use_imm;
        // Branch taken on equality (BEQ) rather than inequality (BNE)
        logic                 br_eq;
    } decoded_t;

    // Where the result of an execute slot comes from
    typedef enum logic {
        FU_ALU,
        FU_MUL
    } fu_sel_e;

    typedef struct packed {
        logic                 pending;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::word_t    pc;
        fu_sel_e              sel;
        rv_isa_pkg::word_t    data;
    } slot_t;

    typedef struct packed {
        logic                 valid;
        rv_isa_pkg::word_t    pc;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::word_t    data;
    } commit_t;

    typedef struct packed {
        logic              valid;
        rv_isa_pkg::word_t target;
    } redirect_t;

    typedef enum logic {
        ST_NORMAL,
        ST_FLUSH
    } ex_state_e;

endpackage

//--- rtl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  in_valid_i,
    input  rv_pipe_pkg::fetched_t in_instr_i,
    output logic                  in_ready_o,
    input  logic                  de_ready_i,
    output logic                  de_valid_o,
    output rv_pipe_pkg::decoded_t de_instr_o,
    output rv_isa_pkg::reg_idx_t  rs1_sel_o,
    output rv_isa_pkg::reg_idx_t  rs2_sel_o
);

    rv_isa_pkg::instr_t    instr;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    rv_pipe_pkg::decoded_t dec;
    rv_pipe_pkg::decoded_t de_q;
    logic                  de_valid_q;

    assign instr  = in_instr_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    // Anything outside the subset stays a NOP with no sources and rd 0
    always_comb begin
        dec = '0;
        dec.pc = in_instr_i.pc;
        dec.op_type = rv_pipe_pkg::OP_NOP;
        dec.alu_op = rv_pipe_pkg::ALU_ADD;
        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                dec.op_type = rv_pipe_pkg::OP_ALU;
                if (funct7 == rv_isa_pkg::F7_MULDIV && funct3 == rv_isa_pkg::F3_ADD) begin
                    // MUL shares funct3 000 with ADD
                    dec.op_type = rv_pipe_pkg::OP_MUL;
                end else if (funct7 == rv_isa_pkg::F7_SUB && funct3 == rv_isa_pkg::F3_ADD) begin
                    dec.alu_op = rv_pipe_pkg::ALU_SUB;
                end else if (funct7 == rv_isa_pkg::F7_BASE) begin
                    case (funct3)
                        rv_isa_pkg::F3_ADD: dec.alu_op = rv_pipe_pkg::ALU_ADD;
                        rv_isa_pkg::F3_AND: dec.alu_op = rv_pipe_pkg::ALU_AND;
                        rv_isa_pkg::F3_OR:  dec.alu_op = rv_pipe_pkg::ALU_OR;
                        rv_isa_pkg::F3_XOR: dec.alu_op = rv_pipe_pkg::ALU_XOR;
                        rv_isa_pkg::F3_SLT: dec.alu_op = rv_pipe_pkg::ALU_SLT;
                        default: dec.op_type = rv_pipe_pkg::OP_NOP;
                    endcase
                end else begin
                    dec.op_type = rv_pipe_pkg::OP_NOP;
                end
                if (dec.op_type != rv_pipe_pkg::OP_NOP) begin
                    dec.rs1 = instr[19:15];
                    dec.rs2 = instr[24:20];
                    dec.rd = instr[11:7];
                end
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                // Only ADDI is supported here
                if (funct3 == rv_isa_pkg::F3_ADD) begin
                    dec.op_type = rv_pipe_pkg::OP_ALU;
                    dec.rs1 = instr[19:15];
                    dec.rd = instr[11:7];
                    dec.imm = {{20{instr[31]}}, instr[31:20]};
                    dec.use_imm = 1'b1;
                end
            end
            rv_isa_pkg::OPC_BRANCH: begin
                if (funct3 == rv_isa_pkg::F3_BEQ || funct3 == rv_isa_pkg::F3_BNE) begin
                    dec.op_type = rv_pipe_pkg::OP_BRANCH;
                    dec.alu_op = rv_pipe_pkg::ALU_SUB;
                    dec.rs1 = instr[19:15];
                    dec.rs2 = instr[24:20];
                    dec.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                               instr[11:8], 1'b0};
                    dec.br_eq = funct3 == rv_isa_pkg::F3_BEQ;
                end
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Decode to execute register
    ////////////////////////////////////////////////////////////

    assign in_ready_o = !de_valid_q || de_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            de_valid_q <= 1'b0;
        end else if (in_valid_i && in_ready_o) begin
            de_valid_q <= 1'b1;
        end else if (de_ready_i) begin
            de_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            de_q <= dec;
        end
    end

    assign de_valid_o = de_valid_q;
    assign de_instr_o = de_q;
    // Register file is addressed straight from the held instruction
    assign rs1_sel_o = de_q.rs1;
    assign rs2_sel_o = de_q.rs2;

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  rv_isa_pkg::reg_idx_t rs1_sel_i,
    input  rv_isa_pkg::reg_idx_t rs2_sel_i,
    output rv_isa_pkg::word_t    rs1_data_o,
    output rv_isa_pkg::word_t    rs2_data_o,
    input  logic                 wr_en_i,
    input  rv_isa_pkg::reg_idx_t wr_sel_i,
    input  rv_isa_pkg::word_t    wr_data_i
);

    // x0 has no storage
    rv_isa_pkg::word_t regs_q [1:31];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && wr_sel_i != '0) begin
            regs_q[wr_sel_i] <= wr_data_i;
        end
    end

    assign rs1_data_o = (rs1_sel_i == '0) ? '0 : regs_q[rs1_sel_i];
    assign rs2_data_o = (rs2_sel_i == '0) ? '0 : regs_q[rs2_sel_i];

endmodule

//--- rtl/exec_pipeline.sv
`timescale 1ns/1ps

module exec_pipeline (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   de_valid_i,
    input  rv_pipe_pkg::decoded_t  de_instr_i,
    output logic                   de_ready_o,
    input  rv_isa_pkg::word_t      rs1_data_i,
    input  rv_isa_pkg::word_t      rs2_data_i,
    input  logic                   ex2_ready_i,
    input  logic                   ex2_fwd_valid_i,
    input  rv_pipe_pkg::slot_t     ex2_fwd_i,
    input  logic                   mul_busy_i,
    input  logic                   mul_done_i,
    input  rv_isa_pkg::word_t      mul_result_i,
    output logic                   mul_start_o,
    output rv_isa_pkg::word_t      mul_a_o,
    output rv_isa_pkg::word_t      mul_b_o,
    output rv_pipe_pkg::slot_t     ex1_slot_o,
    output rv_pipe_pkg::redirect_t redirect_o
);

    rv_pipe_pkg::ex_state_e ex_state_q, ex_state_d;
    logic                   mispredict_q, mispredict_d;
    rv_isa_pkg::word_t      expected_pc_q, expected_pc_d;
    rv_pipe_pkg::slot_t     ex1_q, ex1_view, ex1_d;
    logic                   ex1_data_valid;

    rv_isa_pkg::reg_idx_t src_sel [2];
    rv_isa_pkg::word_t    src_rf [2];
    rv_isa_pkg::word_t    src_val [2];
    logic [1:0]           src_wait;

    logic data_hazard, struct_hazard, control_hazard, ex_issue;

    rv_isa_pkg::word_t op_b, diff, alu_result, npc, br_target;
    logic              lt, eq, taken;

    // A finished multiply in EX1 turns into ALU data
    // unless the unit's result still belongs to EX2
    always_comb begin
        ex1_view = ex1_q;
        ex1_data_valid = 1'b1;
        if (ex1_q.sel == rv_pipe_pkg::FU_MUL) begin
            ex1_data_valid = mul_done_i &&
                !(ex2_fwd_i.pending && ex2_fwd_i.sel == rv_pipe_pkg::FU_MUL);
            if (ex1_data_valid) begin
                ex1_view.sel = rv_pipe_pkg::FU_ALU;
                ex1_view.data = mul_result_i;
            end
        end
    end

    assign ex1_slot_o = ex1_view;

    ////////////////////////////////////////////////////////////
    // Bypass and hazards
    ////////////////////////////////////////////////////////////

    assign src_sel[0] = de_instr_i.rs1;
    assign src_sel[1] = de_instr_i.rs2;
    assign src_rf[0] = rs1_data_i;
    assign src_rf[1] = rs2_data_i;

    // EX1 is younger than EX2 and wins when both match
    always_comb begin
        src_val = src_rf;
        src_wait = '0;
        for (int i = 0; i < 2; i++) begin
            if (ex2_fwd_i.pending && ex2_fwd_i.rd == src_sel[i] && src_sel[i] != '0) begin
                src_val[i] = ex2_fwd_i.data;
                src_wait[i] = !ex2_fwd_valid_i;
            end
            if (ex1_q.pending && ex1_q.rd == src_sel[i] && src_sel[i] != '0) begin
                src_val[i] = ex1_view.data;
                src_wait[i] = !ex1_data_valid;
            end
        end
    end

    assign data_hazard = |src_wait;
    assign struct_hazard = (ex1_q.pending && !ex2_ready_i) ||
                           (de_instr_i.op_type == rv_pipe_pkg::OP_MUL && mul_busy_i);
    assign control_hazard = de_instr_i.pc != expected_pc_q;

    assign ex_issue = de_valid_i && !data_hazard && !struct_hazard && !control_hazard;
    // Wrong-path instructions are always taken in and dropped
    assign de_ready_o = (!data_hazard && !struct_hazard) || control_hazard;

    ////////////////////////////////////////////////////////////
    // ALU and branch
    ////////////////////////////////////////////////////////////

    assign op_b = de_instr_i.use_imm ? de_instr_i.imm : src_val[1];
    // One subtractor serves SUB, SLT and the branch compare
    assign diff = src_val[0] - op_b;
    assign eq = diff == '0;
    assign lt = (src_val[0][rv_isa_pkg::XLEN-1] != op_b[rv_isa_pkg::XLEN-1]) ?
                src_val[0][rv_isa_pkg::XLEN-1] : diff[rv_isa_pkg::XLEN-1];
    assign taken = de_instr_i.br_eq ? eq : !eq;
    assign npc = de_instr_i.pc + rv_isa_pkg::word_t'(rv_isa_pkg::INSTR_BYTES);
    assign br_target = de_instr_i.pc + de_instr_i.imm;

    always_comb begin
        case (de_instr_i.alu_op)
            rv_pipe_pkg::ALU_SUB: alu_result = diff;
            rv_pipe_pkg::ALU_AND: alu_result = src_val[0] & op_b;
            rv_pipe_pkg::ALU_OR:  alu_result = src_val[0] | op_b;
            rv_pipe_pkg::ALU_XOR: alu_result = src_val[0] ^ op_b;
            rv_pipe_pkg::ALU_SLT: alu_result = {{(rv_isa_pkg::XLEN-1){1'b0}}, lt};
            default:              alu_result = src_val[0] + op_b;
        endcase
    end

    assign mul_start_o = ex_issue && de_instr_i.op_type == rv_pipe_pkg::OP_MUL;
    assign mul_a_o = src_val[0];
    assign mul_b_o = src_val[1];

    ////////////////////////////////////////////////////////////
    // Control state and redirect
    ////////////////////////////////////////////////////////////

    always_comb begin
        ex_state_d = ex_state_q;
        mispredict_d = mispredict_q;
        redirect_o.valid = 1'b0;
        redirect_o.target = expected_pc_q;
        if (ex_state_q == rv_pipe_pkg::ST_NORMAL) begin
            if (de_valid_i && de_ready_o) begin
                mispredict_d = control_hazard;
            end
            // Only the first wrong-path instruction raises the redirect
            redirect_o.valid = !mispredict_q && de_valid_i && control_hazard;
        end else begin
            mispredict_d = 1'b0;
            if (ex_issue) begin
                ex_state_d = rv_pipe_pkg::ST_NORMAL;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // EX1 slot
    ////////////////////////////////////////////////////////////

    always_comb begin
        ex1_d = ex1_view;
        expected_pc_d = expected_pc_q;
        if (ex2_ready_i) begin
            ex1_d.pending = 1'b0;
        end
        if (ex_issue) begin
            ex1_d.pending = 1'b1;
            ex1_d.rd = de_instr_i.rd;
            ex1_d.pc = de_instr_i.pc;
            ex1_d.sel = rv_pipe_pkg::FU_ALU;
            ex1_d.data = alu_result;
            expected_pc_d = npc;
            case (de_instr_i.op_type)
                rv_pipe_pkg::OP_MUL: ex1_d.sel = rv_pipe_pkg::FU_MUL;
                rv_pipe_pkg::OP_BRANCH: begin
                    ex1_d.data = '0;
                    expected_pc_d = taken ? br_target : npc;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex_state_q <= rv_pipe_pkg::ST_FLUSH;
            mispredict_q <= 1'b0;
            expected_pc_q <= '0;
            ex1_q <= '0;
        end else begin
            ex_state_q <= ex_state_d;
            mispredict_q <= mispredict_d;
            expected_pc_q <= expected_pc_d;
            ex1_q <= ex1_d;
        end
    end

endmodule

//--- rtl/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              start_i,
    input  rv_isa_pkg::word_t a_i,
    input  rv_isa_pkg::word_t b_i,
    output logic              busy_o,
    output logic              done_o,
    output rv_isa_pkg::word_t result_o
);

    localparam int CNT_W = $clog2(rv_pipe_pkg::MUL_CYCLES);

    logic              busy_q, done_q;
    logic [CNT_W-1:0]  cnt_q;
    rv_isa_pkg::word_t acc_q, mcand_q, mplier_q;

    // Done holds until the next start so a stalled slot can still collect it
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q <= '0;
        end else if (start_i) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
            cnt_q <= '0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(rv_pipe_pkg::MUL_CYCLES - 1)) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // One multiplier bit per cycle into the low word of the product
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            acc_q <= '0;
            mcand_q <= a_i;
            mplier_q <= b_i;
        end else if (busy_q) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign busy_o = busy_q;
    assign done_o = done_q;
    assign result_o = acc_q;

endmodule

//--- rtl/retire_stage.sv
`timescale 1ns/1ps

module retire_stage (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  rv_pipe_pkg::slot_t   ex1_slot_i,
    input  logic                 mul_done_i,
    input  rv_isa_pkg::word_t    mul_result_i,
    output logic                 ex2_ready_o,
    output logic                 ex2_fwd_valid_o,
    output rv_pipe_pkg::slot_t   ex2_fwd_o,
    output logic                 wr_en_o,
    output rv_isa_pkg::reg_idx_t wr_sel_o,
    output rv_isa_pkg::word_t    wr_data_o,
    output rv_pipe_pkg::commit_t commit_o
);

    rv_pipe_pkg::slot_t ex2_q;
    logic               data_valid;
    rv_isa_pkg::word_t  data;

    // A multiply in EX2 waits on the unit, anything else is ready
    assign data_valid = ex2_q.sel == rv_pipe_pkg::FU_ALU || mul_done_i;
    assign data = (ex2_q.sel == rv_pipe_pkg::FU_MUL) ? mul_result_i : ex2_q.data;

    assign ex2_ready_o = !ex2_q.pending || data_valid;
    assign ex2_fwd_valid_o = data_valid;

    always_comb begin
        ex2_fwd_o = ex2_q;
        ex2_fwd_o.data = data;
    end

    always_comb begin
        commit_o.valid = ex2_q.pending && data_valid;
        commit_o.pc = ex2_q.pc;
        commit_o.rd = ex2_q.rd;
        commit_o.data = data;
    end

    assign wr_en_o = commit_o.valid;
    assign wr_sel_o = ex2_q.rd;
    assign wr_data_o = data;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex2_q <= '0;
        end else begin
            if (commit_o.valid) begin
                ex2_q.pending <= 1'b0;
            end
            if (ex1_slot_i.pending && ex2_ready_o) begin
                ex2_q <= ex1_slot_i;
            end
        end
    end

endmodule

//--- rtl/rv_exec_core.sv
`timescale 1ns/1ps

module rv_exec_core (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   in_valid_i,
    input  rv_pipe_pkg::fetched_t  in_instr_i,
    output logic                   in_ready_o,
    output rv_pipe_pkg::commit_t   commit_o,
    output rv_pipe_pkg::redirect_t redirect_o
);

    // Decode to execute
    logic                  de_valid, de_ready;
    rv_pipe_pkg::decoded_t de_instr;
    rv_isa_pkg::reg_idx_t  rs1_sel, rs2_sel;
    rv_isa_pkg::word_t     rs1_data, rs2_data;

    // Execute to retire
    rv_pipe_pkg::slot_t ex1_slot, ex2_fwd;
    logic               ex2_ready, ex2_fwd_valid;

    // Multiplier
    logic              mul_start, mul_busy, mul_done;
    rv_isa_pkg::word_t mul_a, mul_b, mul_result;

    // Write-back
    logic                 wr_en;
    rv_isa_pkg::reg_idx_t wr_sel;
    rv_isa_pkg::word_t    wr_data;

    instr_decoder instr_decoder_inst (
        .clk_i, .rst_ni, .in_valid_i, .in_instr_i, .in_ready_o,
        .de_ready_i (de_ready),
        .de_valid_o (de_valid),
        .de_instr_o (de_instr),
        .rs1_sel_o  (rs1_sel),
        .rs2_sel_o  (rs2_sel)
    );

    reg_file reg_file_inst (
        .clk_i, .rst_ni,
        .rs1_sel_i  (rs1_sel),
        .rs2_sel_i  (rs2_sel),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_en_i    (wr_en),
        .wr_sel_i   (wr_sel),
        .wr_data_i  (wr_data)
    );

    exec_pipeline exec_pipeline_inst (
        .clk_i, .rst_ni,
        .de_valid_i      (de_valid),
        .de_instr_i      (de_instr),
        .de_ready_o      (de_ready),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .ex2_ready_i     (ex2_ready),
        .ex2_fwd_valid_i (ex2_fwd_valid),
        .ex2_fwd_i       (ex2_fwd),
        .mul_busy_i      (mul_busy),
        .mul_done_i      (mul_done),
        .mul_result_i    (mul_result),
        .mul_start_o     (mul_start),
        .mul_a_o         (mul_a),
        .mul_b_o         (mul_b),
        .ex1_slot_o      (ex1_slot),
        .redirect_o
    );

    mul_unit mul_unit_inst (
        .clk_i, .rst_ni,
        .start_i  (mul_start),
        .a_i      (mul_a),
        .b_i      (mul_b),
        .busy_o   (mul_busy),
        .done_o   (mul_done),
        .result_o (mul_result)
    );

    retire_stage retire_stage_inst (
        .clk_i, .rst_ni,
        .ex1_slot_i      (ex1_slot),
        .mul_done_i      (mul_done),
        .mul_result_i    (mul_result),
        .ex2_ready_o     (ex2_ready),
        .ex2_fwd_valid_o (ex2_fwd_valid),
        .ex2_fwd_o       (ex2_fwd),
        .wr_en_o         (wr_en),
        .wr_sel_o        (wr_sel),
        .wr_data_o       (wr_data),
        .commit_o
    );

endmodule

//--- tb/rv_exec_core_chk.sv
`timescale 1ns/1ps

module rv_exec_core_chk (
    input logic                   clk_i,
    input logic                   rst_ni,
    input logic                   de_valid_i,
    input logic                   de_ready_i,
    input rv_pipe_pkg::decoded_t  de_instr_i,
    input rv_pipe_pkg::commit_t   commit_i,
    input rv_pipe_pkg::redirect_t redirect_i
);

    rv_isa_pkg::word_t branch_pc_q;
    logic              branch_seen_q;

    // The redirect target always carries the expected PC, so a branch that
    // leaves decode on that PC has issued
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            branch_seen_q <= 1'b0;
            branch_pc_q <= '0;
        end else if (de_valid_i && de_ready_i &&
                     de_instr_i.op_type == rv_pipe_pkg::OP_BRANCH &&
                     de_instr_i.pc == redirect_i.target) begin
            branch_seen_q <= 1'b1;
            branch_pc_q <= de_instr_i.pc;
        end
    end

    redirect_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
        redirect_i.valid |=> !redirect_i.valid)
        else $error("redirect held high for two cycles");

    commit_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        commit_i.valid |-> !$isunknown({commit_i.pc, commit_i.rd, commit_i.data}))
        else $error("commit fields unknown while valid");

    branch_rd_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (commit_i.valid && branch_seen_q && commit_i.pc == branch_pc_q) |->
        commit_i.rd == '0)
        else $error("branch committed with a nonzero rd");

endmodule

bind rv_exec_core rv_exec_core_chk rv_exec_core_chk_inst (
    .clk_i,
    .rst_ni,
    .de_valid_i (de_valid),
    .de_ready_i (de_ready),
    .de_instr_i (de_instr),
    .commit_i   (commit_o),
    .redirect_i (redirect_o)
);

//--- tb/rv_exec_core_tb.sv
`timescale 1ns/1ps

module rv_exec_core_tb;

    localparam int TD_WORDS = 256;
    localparam int MAX_ENTRIES = 64;
    // Quiet cycles watched after the last expected commit
    localparam int TAIL_CYCLES = 10;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   in_valid_i;
    rv_pipe_pkg::fetched_t  in_instr_i;
    logic                   in_ready_o;
    rv_pipe_pkg::commit_t   commit_o;
    rv_pipe_pkg::redirect_t redirect_o;

    logic [31:0]        testdata [0:TD_WORDS-1];
    rv_isa_pkg::instr_t prog_mem [0:MAX_ENTRIES-1];
    rv_isa_pkg::word_t  exp_pc [0:MAX_ENTRIES-1];
    logic [31:0]        exp_rd [0:MAX_ENTRIES-1];
    rv_isa_pkg::word_t  exp_data [0:MAX_ENTRIES-1];
    int                 prog_words;
    int                 exp_count;

    rv_isa_pkg::word_t redirect_targets [$];
    rv_isa_pkg::word_t fetch_pc;
    rv_isa_pkg::word_t redirect_target;
    logic [31:0]       lfsr_q;
    logic              accepted;
    logic              redirected;
    logic              timed_out;
    int                commit_idx;
    int                cycle_count;
    int                cycle_limit;
    int                tail_count;
    int                mismatch_count;
    int                other_count;

    rv_exec_core rv_exec_core_inst (
        .clk_i,
        .rst_ni,
        .in_valid_i,
        .in_instr_i,
        .in_ready_o,
        .commit_o,
        .redirect_o
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else begin
            mismatch_count++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test data
    ////////////////////////////////////////////////////////////

    task automatic load_testdata();
        $readmemh("tb/rv_exec_core_testdata.hex", testdata);
        prog_words = int'(testdata[0]);
        exp_count = int'(testdata[1]);
        assert (prog_words > 0 && prog_words <= MAX_ENTRIES &&
                exp_count > 0 && exp_count <= MAX_ENTRIES) else begin
            other_count++;
            $display("Test data file is missing or its counts are out of range");
            prog_words = 0;
            exp_count = 0;
        end
        for (int i = 0; i < prog_words; i++) begin
            prog_mem[i] = testdata[2 + i];
        end
        for (int i = 0; i < exp_count; i++) begin
            exp_pc[i] = testdata[2 + prog_words + 3 * i];
            exp_rd[i] = testdata[3 + prog_words + 3 * i];
            exp_data[i] = testdata[4 + prog_words + 3 * i];
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Fetch model and output monitor
    ////////////////////////////////////////////////////////////

    task automatic drive_fetch();
        logic idle;
        if (redirected) begin
            fetch_pc = redirect_target;
        end else if (accepted) begin
            fetch_pc = fetch_pc + 32'd4;
        end
        // A word that was offered and not taken stays on the bus
        if (!(in_valid_i && !accepted && !redirected)) begin
            lfsr_q = lfsr_next(lfsr_q);
            idle = lfsr_q[0];
            in_valid_i = !idle && (fetch_pc < 32'(prog_words * 4));
            in_instr_i.pc = fetch_pc;
            in_instr_i.instr = in_valid_i ? prog_mem[fetch_pc[7:2]] : '0;
        end
    endtask

    task automatic check_commit();
        string name;
        assert (commit_idx < exp_count) else begin
            other_count++;
            $display("Unexpected extra commit at PC %h", commit_o.pc);
        end
        if (commit_idx < exp_count) begin
            name = $sformatf("commit %0d", commit_idx);
            compare_word({name, " pc"}, exp_pc[commit_idx], commit_o.pc);
            compare_word({name, " rd"}, exp_rd[commit_idx], 32'(commit_o.rd));
            compare_word({name, " data"}, exp_data[commit_idx], commit_o.data);
        end
        commit_idx++;
    endtask

    task automatic sample_outputs();
        accepted = in_valid_i && in_ready_o;
        redirected = redirect_o.valid;
        redirect_target = redirect_o.target;
        if (redirected) begin
            redirect_targets.push_back(redirect_o.target);
        end
        if (commit_o.valid) begin
            check_commit();
        end
    endtask

    task automatic check_reset_state();
        compare_word("reset commit valid", 32'd0, 32'(commit_o.valid));
        compare_word("reset redirect valid", 32'd0, 32'(redirect_o.valid));
        compare_word("reset in_ready", 32'd1, 32'(in_ready_o));
    endtask

    // A taken branch shows up as a jump in the expected commit PCs
    task automatic check_redirects();
        rv_isa_pkg::word_t expected_targets [$];
        for (int i = 0; i + 1 < exp_count; i++) begin
            if (exp_pc[i + 1] != exp_pc[i] + 32'd4) begin
                expected_targets.push_back(exp_pc[i + 1]);
            end
        end
        assert (redirect_targets.size() == expected_targets.size()) else begin
            other_count++;
            $display("Expected %0d redirects but saw %0d",
                     expected_targets.size(), redirect_targets.size());
        end
        for (int i = 0; i < expected_targets.size() && i < redirect_targets.size(); i++) begin
            compare_word($sformatf("redirect %0d target", i), expected_targets[i],
                         redirect_targets[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst_ni = 1'b0;
        in_valid_i = 1'b0;
        in_instr_i = '0;
        lfsr_q = 32'hbde5_9a24;
        fetch_pc = '0;
        redirect_target = '0;
        accepted = 1'b0;
        redirected = 1'b0;
        timed_out = 1'b0;
        commit_idx = 0;
        cycle_count = 0;
        tail_count = 0;
        mismatch_count = 0;
        other_count = 0;
        load_testdata();
        cycle_limit = exp_count * (rv_pipe_pkg::MUL_CYCLES + 8);

        repeat (5) @(posedge clk_i);
        #1 rst_ni = 1'b1;
        @(negedge clk_i);
        check_reset_state();

        // Drive just after the rising edge, look at the outputs at the falling edge
        while (tail_count < TAIL_CYCLES && !timed_out) begin
            @(posedge clk_i);
            #1;
            drive_fetch();
            @(negedge clk_i);
            sample_outputs();
            cycle_count++;
            if (commit_idx >= exp_count) begin
                tail_count++;
            end
            if (cycle_count >= cycle_limit) begin
                timed_out = 1'b1;
            end
        end

        if (timed_out) begin
            other_count++;
            $display("Timeout after %0d cycles with %0d of %0d commits seen",
                     cycle_count, commit_idx, exp_count);
        end
        check_redirects();

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- tb/rv_exec_core_testdata.hex
// Two counts (program words, expected commits), then the program words,
// then one expected commit per line with columns pc, rd, value
0000001C
00000017
// Program words, four per line from PC 0
00500093 00308113 002081B3 40118233
002242B3 0041E333 0021F3B3 00322433
FF900493 0014A533 0090A5B3 02418633
001606B3 02948733 00220663 00100A13
00200A93 00109863 00708013 00E007B3
00C79863 00300B13 00400B93 00500C13
7FF00813 FFFFFFFF 40D808B3 0108C933
// Expected commits in program order
00000000 01 00000005
00000004 02 00000008
00000008 03 0000000D
0000000C 04 00000008
00000010 05 00000000
00000014 06 0000000D
00000018 07 00000008
0000001C 08 00000001
00000020 09 FFFFFFF9
00000024 0A 00000001
00000028 0B 00000000
0000002C 0C 00000068
00000030 0D 0000006D
00000034 0E 00000031
00000038 00 00000000
00000044 00 00000000
00000048 00 0000000C
0000004C 0F 00000031
00000050 00 00000000
00000060 10 000007FF
00000064 00 00000000
00000068 11 00000792
0000006C 12 0000006D

//--- rv_exec_core.f
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/exec_pipeline.sv
rtl/mul_unit.sv
rtl/retire_stage.sv
rtl/rv_exec_core.sv
tb/rv_exec_core_chk.sv
tb/rv_exec_core_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module rv_exec_core_tb -f rv_exec_core.f -Mdir obj_dir
	./obj_dir/Vrv_exec_core_tb | tee sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
